//--- vlog.f
+incdir+source
source/rv_isa_pkg.sv
source/pipe_pkg.sv
source/bypass_if.sv
source/register_file.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/memory_stage.sv
source/riscv_core.sv
bench/tb_riscv_core.sv

//--- run.sh
#!/bin/sh
verilator --binary -f vlog.f --top-module tb_riscv_core || { echo "build failed"; exit 1; }
out=$(./obj_dir/Vtb_riscv_core)
echo "$out"
echo "$out" | grep -q "STATUS: PASS" && echo "run passed" || { echo "run failed"; exit 1; }

//--- bench/tb_riscv_core.sv
// pipelined core testbench
`include "rv_macros.svh"

module tb_riscv_core;
  timeunit 1ns;
  timeprecision 100ps;

  // instruction kinds for the encoder and generator
  localparam int K_ADD = 0, K_SUB = 1, K_AND = 2, K_OR = 3, K_XOR = 4, K_SLT = 5;
  localparam int K_ADDI = 6, K_ANDI = 7, K_ORI = 8, K_XORI = 9;
  localparam int K_LW = 10, K_SW = 11, K_BEQ = 12, K_BNE = 13, K_JAL = 14, K_ECALL = 15;
  localparam int HALT_WAIT = 2000;  // cycles allowed per program
  localparam int DRAIN_CYCLES = 5;  // one pipeline depth

  logic             clk;
  logic             reset;
  logic [`XLEN-1:0] imem_addr;
  logic [`XLEN-1:0] imem_data;
  logic             is_halted;
  logic [`XLEN-1:0] print_reg [`REG_COUNT];

  logic [31:0] prog [256];       // program owned by the testbench
  logic [7:0]  plen;             // next free slot
  logic [31:0] ref_regs [32];    // model state after ref_run
  logic [31:0] ref_mem [64];
  logic [31:0] rng = 32'd13;
  int          programs = 0;
  int          errors = 0;
  int          timeouts = 0;

  riscv_core i_dut (
    .clk       (clk),
    .reset     (reset),
    .imem_addr (imem_addr),
    .imem_data (imem_data),
    .is_halted (is_halted),
    .print_reg (print_reg)
  );

  assign imem_data = prog[imem_addr[9:2]];  // same-cycle word lookup

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] xorshift();
    rng ^= rng << 13;
    rng ^= rng >> 17;
    rng ^= rng << 5;
    return rng;
  endfunction

  function automatic int rand_below(int n);
    return int'(xorshift() % n);
  endfunction

  // rv32i encoding straight from the isa formats
  function automatic logic [31:0] encode(int kind, int rd, int rs1, int rs2, int imm);
    logic [2:0] f3;
    case (kind)
      K_SLT, K_LW, K_SW:    f3 = 3'b010;
      K_XOR, K_XORI:        f3 = 3'b100;
      K_OR, K_ORI:          f3 = 3'b110;
      K_AND, K_ANDI:        f3 = 3'b111;
      K_BNE:                f3 = 3'b001;
      default:              f3 = 3'b000;  // add sub addi beq
    endcase
    case (kind)
      K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_SLT:
        return {(kind == K_SUB) ? 7'h20 : 7'h00, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
      K_ADDI, K_ANDI, K_ORI, K_XORI:
        return {imm[11:0], rs1[4:0], f3, rd[4:0], 7'b0010011};
      K_LW:
        return {imm[11:0], rs1[4:0], f3, rd[4:0], 7'b0000011};
      K_SW:
        return {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], 7'b0100011};
      K_BEQ, K_BNE:
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], 7'b1100011};
      K_JAL:
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
      default:
        return 32'h0000_0073;  // ecall
    endcase
  endfunction

  function automatic void clear_program();
    for (int i = 0; i < 256; i++)
      prog[i] = {12'(i), 13'd0, 7'b0010011};  // addi x0, x0, i
    plen = '0;
  endfunction

  function automatic void emit(int kind, int rd, int rs1, int rs2, int imm);
    prog[plen] = encode(kind, rd, rs1, rs2, imm);
    plen = plen + 8'd1;
  endfunction

  function automatic void finish_program();
    emit(K_ADDI, `ECALL_ARG_REG, 0, 0, `HALT_CODE);
    emit(K_ECALL, 0, 0, 0, 0);
  endfunction

  // sequential interpreter stepping one instruction at a time
  function automatic void ref_run();
    logic [31:0] w, a, b, op2, res, imm_i, imm_s, imm_b, imm_j, addr;
    logic [7:0]  pc, npc;
    logic [4:0]  rd;
    logic        wr;
    for (int i = 0; i < 32; i++)
      ref_regs[i] = '0;
    for (int i = 0; i < 64; i++)
      ref_mem[i] = '0;
    pc = '0;
    for (int step = 0; step < 1000; step++) begin
      w     = prog[pc];
      a     = ref_regs[w[19:15]];
      b     = ref_regs[w[24:20]];
      rd    = w[11:7];
      imm_i = {{20{w[31]}}, w[31:20]};
      imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
      imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
      imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
      npc   = pc + 8'd1;
      wr    = 1'b0;
      res   = '0;
      case (w[6:0])
        7'b0110011, 7'b0010011: begin
          op2 = w[5] ? b : imm_i;  // bit 5 marks register form
          wr  = 1'b1;
          case (w[14:12])
            3'b000:  res = (w[5] && w[30]) ? a - op2 : a + op2;
            3'b010:  res = {31'b0, $signed(a) < $signed(op2)};
            3'b100:  res = a ^ op2;
            3'b110:  res = a | op2;
            3'b111:  res = a & op2;
            default: wr = 1'b0;
          endcase
        end
        7'b0000011: begin
          addr = a + imm_i;
          res  = ref_mem[addr[7:2]];
          wr   = 1'b1;
        end
        7'b0100011: begin
          addr = a + imm_s;
          ref_mem[addr[7:2]] = b;
        end
        7'b1100011: if ((a == b) != w[12]) npc = pc + imm_b[9:2];  // funct3 bit 0 is bne
        7'b1101111: begin
          res = {22'b0, npc, 2'b00};  // link = pc + 4
          wr  = 1'b1;
          npc = pc + imm_j[9:2];
        end
        7'b1110011: if (ref_regs[`ECALL_ARG_REG] == 32'(`HALT_CODE)) return;
        default: ;
      endcase
      if (wr && rd != 5'd0)
        ref_regs[rd] = res;
      pc = npc;
    end
  endfunction

  // reset state sampled just before release
  task automatic check_idle();
    if (is_halted !== 1'b0) begin
      errors++;
      $display("[FAIL] %0t: is_halted %b during reset", $time, is_halted);
    end
    if (imem_addr !== '0) begin
      errors++;
      $display("[FAIL] %0t: imem_addr %h during reset", $time, imem_addr);
    end
    for (int i = 0; i < `REG_COUNT; i++)
      if (print_reg[i] !== '0) begin
        errors++;
        $display("[FAIL] %0t: x%0d is %h during reset", $time, i, print_reg[i]);
      end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    reset <= 1'b1;
    repeat (7) @(posedge clk);
    @(negedge clk);
    check_idle();
    @(posedge clk);
    reset <= 1'b0;  // eighth edge still sees reset
  endtask

  task automatic wait_for_halt(input string name, output bit done);
    int cycles;
    cycles = 0;
    while (is_halted !== 1'b1 && cycles < HALT_WAIT) begin
      @(negedge clk);
      cycles++;
    end
    done = (is_halted === 1'b1);
    if (!done) begin
      timeouts++;
      $display("timeout: program %s did not halt within %0d cycles", name, HALT_WAIT);
    end
  endtask

  task automatic compare_regs(input string name);
    for (int i = 0; i < `REG_COUNT; i++)
      if (print_reg[i] !== ref_regs[i]) begin
        errors++;
        $display("[FAIL] %0t: %s x%0d expected %h got %h",
                 $time, name, i, ref_regs[i], print_reg[i]);
      end
  endtask

  task automatic run_program(input string name);
    bit done;
    ref_run();
    apply_reset();
    wait_for_halt(name, done);
    if (done) begin
      repeat (DRAIN_CYCLES) @(negedge clk);  // younger words reach wb
      if (is_halted !== 1'b1) begin
        errors++;
        $display("[FAIL] %0t: %s is_halted dropped after the halt", $time, name);
      end
      compare_regs(name);
    end
    programs++;
  endtask

  // init block, 30 body ops on x1..x7, then the halt pair
  function automatic void make_random_program();
    int kind, rd, ra, rb, imm, word_off, lim, off;
    clear_program();
    for (int r = 1; r <= 7; r++)
      emit(K_ADDI, r, 0, 0, rand_below(4096) - 2048);
    for (int k = 0; k < 30; k++) begin
      kind     = rand_below(15);
      rd       = 1 + rand_below(7);
      ra       = 1 + rand_below(7);
      rb       = 1 + rand_below(7);
      imm      = rand_below(4096) - 2048;
      word_off = 4 * rand_below(16);
      lim      = (30 - k < 3) ? 30 - k : 3;  // never past the addi x17
      off      = 4 * (1 + rand_below(lim));
      case (kind)
        K_LW:         emit(K_LW, rd, 0, 0, word_off);
        K_SW:         emit(K_SW, 0, 0, rb, word_off);
        K_BEQ, K_BNE: emit(kind, 0, ra, rb, off);
        K_JAL:        emit(K_JAL, rd, 0, 0, off);
        default:      emit(kind, rd, ra, rb, imm);
      endcase
    end
    finish_program();
  endfunction

  initial begin
    reset = 1'b1;
    clear_program();

    // back-to-back dependencies and x0 as a target
    emit(K_ADDI, 1, 0, 0, 5);
    emit(K_ADDI, 2, 1, 0, 3);   // from mem
    emit(K_ADD, 3, 2, 1, 0);    // mem and wb
    emit(K_SUB, 4, 3, 2, 0);
    emit(K_XOR, 5, 4, 1, 0);
    emit(K_SLT, 6, 4, 3, 0);
    emit(K_ADDI, 0, 0, 0, 99);
    emit(K_ADD, 7, 0, 3, 0);    // x0 not forwarded
    emit(K_OR, 1, 5, 6, 0);
    emit(K_AND, 2, 1, 7, 0);
    finish_program();
    run_program("forward_chain");

    clear_program();
    emit(K_ADDI, 1, 0, 0, 77);
    emit(K_ADDI, 2, 0, 0, 8);
    emit(K_SW, 0, 2, 1, 4);     // word 3
    emit(K_LW, 3, 0, 0, 12);
    emit(K_ADD, 4, 3, 3, 0);    // load-use
    emit(K_LW, 5, 0, 0, 12);
    emit(K_SW, 0, 0, 5, 16);    // loaded store data
    emit(K_LW, 6, 0, 0, 16);
    emit(K_ADDI, 7, 6, 0, 1);
    finish_program();
    run_program("load_use");

    clear_program();
    emit(K_ADDI, 1, 0, 0, 4);
    emit(K_ADDI, 2, 0, 0, 4);
    emit(K_BEQ, 0, 1, 2, 12);   // taken and skips two
    emit(K_ADDI, 3, 0, 0, 111);
    emit(K_ADDI, 4, 0, 0, 222);
    emit(K_BNE, 0, 1, 2, 8);    // not taken
    emit(K_ADDI, 5, 0, 0, 55);
    emit(K_BEQ, 0, 1, 0, 8);    // not taken
    emit(K_JAL, 6, 0, 0, 12);
    emit(K_ADDI, 7, 0, 0, 1);
    emit(K_ADDI, 3, 0, 0, 2);
    emit(K_BNE, 0, 1, 0, 8);    // taken
    emit(K_ADDI, 4, 0, 0, 3);
    emit(K_ADD, 7, 6, 1, 0);    // link through forwarding
    finish_program();
    run_program("branch_jal");

    clear_program();
    emit(K_ADDI, 1, 0, 0, 1);
    finish_program();           // x17 set right before ecall
    emit(K_ADDI, 2, 0, 0, 9);
    run_program("halt_direct");

    clear_program();
    emit(K_ADDI, `ECALL_ARG_REG, 0, 0, 7);
    emit(K_ECALL, 0, 0, 0, 0);  // no halt
    emit(K_ADDI, 3, 0, 0, 33);
    finish_program();
    emit(K_ADDI, 4, 0, 0, 44);
    emit(K_ADDI, 5, 0, 0, 55);
    run_program("halt_second");

    for (int n = 0; n < 20; n++) begin
      make_random_program();
      run_program($sformatf("random_%0d", n));
    end

    $display("programs %0d, mismatches %0d, timeouts %0d", programs, errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end
endmodule

//--- source/riscv_core.sv
// five-stage rv32i core
`include "rv_macros.svh"

module riscv_core (
  input  logic             clk,
  input  logic             reset,
  output logic [`XLEN-1:0] imem_addr,
  input  logic [`XLEN-1:0] imem_data,
  output logic             is_halted,
  output logic [`XLEN-1:0] print_reg [`REG_COUNT]
);
  import pipe_pkg::*;

  if_id_t           if_id;
  id_ex_t           id_ex;
  ex_mem_t          ex_mem;
  logic             stall;        // decode -> fetch
  logic             redirect;     // execute -> fetch, decode
  logic [`XLEN-1:0] redirect_pc;

  bypass_if bypass ();  // mem/wb results back to id and ex

  fetch_stage i_fetch (
    .clk         (clk),
    .reset       (reset),
    .stall       (stall),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .imem_addr   (imem_addr),
    .imem_data   (imem_data),
    .if_id       (if_id)
  );

  decode_stage i_decode (
    .clk       (clk),
    .reset     (reset),
    .if_id     (if_id),
    .redirect  (redirect),
    .bypass    (bypass.dec),
    .stall     (stall),
    .id_ex     (id_ex),
    .print_reg (print_reg)
  );

  execute_stage i_execute (
    .clk         (clk),
    .reset       (reset),
    .id_ex       (id_ex),
    .bypass      (bypass.fwd),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .ex_mem      (ex_mem)
  );

  memory_stage i_memory (
    .clk       (clk),
    .reset     (reset),
    .ex_mem    (ex_mem),
    .bypass    (bypass.source),
    .is_halted (is_halted)
  );
endmodule

//--- source/memory_stage.sv
// data memory, writeback select and halt
`include "rv_macros.svh"

module memory_stage (
  input  logic              clk,
  input  logic              reset,
  input  pipe_pkg::ex_mem_t ex_mem,
  bypass_if.source          bypass,
  output logic              is_halted
);
  logic [`XLEN-1:0]              dmem [`DMEM_WORDS];
  logic [$clog2(`DMEM_WORDS)-1:0] word_idx;
  logic [`XLEN-1:0]              mem_value, wb_din;
  logic [`REG_ADDR_W-1:0]        wb_rd;
  logic                          wb_reg_write;
  logic [`XLEN-1:0]              wb_value;
  logic                          halted;

  assign word_idx  = ex_mem.alu_out[$clog2(`DMEM_WORDS)+1:2];    // byte address to word
  assign mem_value = ex_mem.ctrl.is_jal ? ex_mem.link : ex_mem.alu_out;
  assign wb_din    = ex_mem.ctrl.mem_read ? dmem[word_idx] : mem_value;  // async load

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `DMEM_WORDS; i++)
        dmem[i] <= '0;
    end else if (ex_mem.ctrl.mem_write && !halted) begin
      dmem[word_idx] <= ex_mem.store_data;
    end
  end

  // mem/wb register and sticky halt
  always_ff @(posedge clk) begin
    if (reset) begin
      wb_reg_write <= 1'b0;
      halted       <= 1'b0;
    end else begin
      wb_reg_write <= ex_mem.ctrl.reg_write;
      halted       <= halted | ex_mem.ctrl.is_halt;  // set as ecall enters wb
    end
    wb_rd    <= ex_mem.rd;
    wb_value <= wb_din;
  end

  assign bypass.mem_rd        = ex_mem.rd;
  assign bypass.mem_reg_write = ex_mem.ctrl.reg_write;
  assign bypass.mem_mem_read  = ex_mem.ctrl.mem_read;
  assign bypass.mem_value     = mem_value;
  assign bypass.wb_rd         = wb_rd;
  assign bypass.wb_reg_write  = wb_reg_write && !halted;  // no writes past the halt
  assign bypass.wb_value      = wb_value;

  assign is_halted = halted;
endmodule

//--- source/execute_stage.sv
// execute, forwarding and branch resolve
`include "rv_macros.svh"

module execute_stage (
  input  logic              clk,
  input  logic              reset,
  input  pipe_pkg::id_ex_t  id_ex,
  bypass_if.fwd             bypass,
  output logic              redirect,
  output logic [`XLEN-1:0]  redirect_pc,
  output pipe_pkg::ex_mem_t ex_mem
);
  import rv_isa_pkg::*;
  import pipe_pkg::*;

  logic             mem_hit_a, mem_hit_b, wb_hit_a, wb_hit_b;
  logic [`XLEN-1:0] op_a, op_b, alu_b, alu_out;
  logic             equal;
  ex_mem_t          ex_mem_d;

  // nonzero rd matches, mem is the younger result
  assign mem_hit_a = bypass.mem_reg_write && bypass.mem_rd != '0 && bypass.mem_rd == id_ex.rs1;
  assign mem_hit_b = bypass.mem_reg_write && bypass.mem_rd != '0 && bypass.mem_rd == id_ex.rs2;
  assign wb_hit_a  = bypass.wb_reg_write && bypass.wb_rd != '0 && bypass.wb_rd == id_ex.rs1;
  assign wb_hit_b  = bypass.wb_reg_write && bypass.wb_rd != '0 && bypass.wb_rd == id_ex.rs2;

  assign op_a = mem_hit_a ? bypass.mem_value : wb_hit_a ? bypass.wb_value : id_ex.rs1_data;
  assign op_b = mem_hit_b ? bypass.mem_value : wb_hit_b ? bypass.wb_value : id_ex.rs2_data;

  assign alu_b = id_ex.ctrl.alu_src ? id_ex.imm : op_b;

  always_comb begin
    case (id_ex.ctrl.alu_op)
      ALU_ADD: alu_out = op_a + alu_b;
      ALU_SUB: alu_out = op_a - alu_b;
      ALU_AND: alu_out = op_a & alu_b;
      ALU_OR:  alu_out = op_a | alu_b;
      ALU_XOR: alu_out = op_a ^ alu_b;
      ALU_SLT: alu_out = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(alu_b)};
      default: alu_out = op_a + alu_b;
    endcase
  end

  // beq/bne compare on forwarded registers, not the alu
  assign equal       = (op_a == op_b);
  assign redirect    = id_ex.ctrl.is_jal ||
                       (id_ex.ctrl.is_branch && (equal ^ id_ex.ctrl.branch_ne));
  assign redirect_pc = id_ex.pc + id_ex.imm;  // pc-relative target

  always_comb begin
    ex_mem_d.ctrl       = id_ex.ctrl;
    ex_mem_d.alu_out    = alu_out;
    ex_mem_d.store_data = op_b;               // sw data, forwarded
    ex_mem_d.rd         = id_ex.rd;
    ex_mem_d.link       = id_ex.pc + `XLEN'(`PC_STEP);
  end

  always_ff @(posedge clk) begin
    if (reset)
      ex_mem.ctrl <= '0;
    else
      ex_mem <= ex_mem_d;
  end
endmodule

//--- source/decode_stage.sv
// instruction decode and hazard check
`include "rv_macros.svh"

module decode_stage (
  input  logic             clk,
  input  logic             reset,
  input  pipe_pkg::if_id_t if_id,
  input  logic             redirect,
  bypass_if.dec            bypass,
  output logic             stall,
  output pipe_pkg::id_ex_t id_ex,
  output logic [`XLEN-1:0] print_reg [`REG_COUNT]
);
  import rv_isa_pkg::*;
  import pipe_pkg::*;

  inst_u                  inst;
  ctrl_t                  ctrl;
  id_ex_t                 id_ex_d;
  logic [`XLEN-1:0]       imm;
  logic                   uses_rs1, uses_rs2;
  logic                   is_ecall;
  logic [`REG_ADDR_W-1:0] rs1_addr;
  logic [`XLEN-1:0]       rs1_dout, rs2_dout;
  logic [`XLEN-1:0]       ecall_arg;
  logic                   load_use, ecall_wait;

  function automatic alu_op_e alu_from_f3(input logic [2:0] funct3, input logic sub);
    case (funct3)
      3'b000:  return sub ? ALU_SUB : ALU_ADD;
      3'b010:  return ALU_SLT;
      3'b100:  return ALU_XOR;
      3'b110:  return ALU_OR;
      3'b111:  return ALU_AND;
      default: return ALU_ADD;
    endcase
  endfunction

  assign inst     = if_id.inst;
  assign is_ecall = (inst.r.opcode == OP_SYSTEM);
  assign rs1_addr = is_ecall ? `REG_ADDR_W'(`ECALL_ARG_REG) : inst.r.rs1;  // ecall reads a7

  register_file i_regs (
    .clk          (clk),
    .reset        (reset),
    .rs1_addr     (rs1_addr),
    .rs2_addr     (inst.r.rs2),
    .rd           (bypass.wb_rd),
    .rd_din       (bypass.wb_value),
    .write_enable (bypass.wb_reg_write),
    .rs1_dout     (rs1_dout),
    .rs2_dout     (rs2_dout),
    .print_reg    (print_reg)
  );

  // a7 for ecall from mem, else from the write-through register file
  always_comb begin
    if (bypass.mem_reg_write && bypass.mem_rd == `REG_ADDR_W'(`ECALL_ARG_REG))
      ecall_arg = bypass.mem_value;
    else
      ecall_arg = rs1_dout;
  end

  always_comb begin
    ctrl     = '0;
    imm      = '0;
    uses_rs1 = 1'b0;
    uses_rs2 = 1'b0;
    case (inst.r.opcode)
      OP_R: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = alu_from_f3(inst.r.funct3, inst.r.funct7[5]);
        uses_rs1       = 1'b1;
        uses_rs2       = 1'b1;
      end
      OP_IMM: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src   = 1'b1;
        ctrl.alu_op    = alu_from_f3(inst.i.funct3, 1'b0);  // no subi
        imm            = {{(`XLEN-12){inst.i.imm[11]}}, inst.i.imm};
        uses_rs1       = 1'b1;
      end
      OP_LOAD: begin
        ctrl.reg_write = 1'b1;
        ctrl.mem_read  = 1'b1;
        ctrl.alu_src   = 1'b1;  // address = rs1 + imm
        imm            = {{(`XLEN-12){inst.i.imm[11]}}, inst.i.imm};
        uses_rs1       = 1'b1;
      end
      OP_STORE: begin
        ctrl.mem_write = 1'b1;
        ctrl.alu_src   = 1'b1;
        imm            = {{(`XLEN-12){inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
        uses_rs1       = 1'b1;
        uses_rs2       = 1'b1;  // store data
      end
      OP_BRANCH: begin
        ctrl.is_branch = 1'b1;
        ctrl.branch_ne = inst.b.funct3[0];  // 000 beq, 001 bne
        imm            = {{(`XLEN-12){inst.b.imm12}}, inst.b.imm11,
                          inst.b.imm10_5, inst.b.imm4_1, 1'b0};
        uses_rs1       = 1'b1;
        uses_rs2       = 1'b1;
      end
      OP_JAL: begin
        ctrl.reg_write = 1'b1;  // rd = pc + 4
        ctrl.is_jal    = 1'b1;
        imm            = {{(`XLEN-20){inst.j.imm20}}, inst.j.imm19_12,
                          inst.j.imm11, inst.j.imm10_1, 1'b0};
      end
      OP_SYSTEM: begin
        ctrl.is_halt = (ecall_arg == `XLEN'(`HALT_CODE));
        uses_rs1     = 1'b1;  // a7 via rs1_addr
      end
      default: ;  // unknown word acts as nop
    endcase
  end

  // load in EX feeding a source of this instruction
  assign load_use = id_ex.ctrl.mem_read && id_ex.rd != '0 &&
                    ((uses_rs1 && id_ex.rd == rs1_addr) ||
                     (uses_rs2 && id_ex.rd == inst.r.rs2));
  // ecall has no EX forward or MEM load data and waits for a7
  assign ecall_wait = is_ecall &&
                      ((id_ex.ctrl.reg_write && id_ex.rd == `REG_ADDR_W'(`ECALL_ARG_REG)) ||
                       (bypass.mem_mem_read && bypass.mem_reg_write &&
                        bypass.mem_rd == `REG_ADDR_W'(`ECALL_ARG_REG)));
  assign stall = if_id.valid && (load_use || ecall_wait);

  always_comb begin
    id_ex_d          = '0;
    id_ex_d.ctrl     = (stall || redirect || !if_id.valid) ? '0 : ctrl;  // bubble
    id_ex_d.pc       = if_id.pc;
    id_ex_d.rs1_data = rs1_dout;
    id_ex_d.rs2_data = rs2_dout;
    id_ex_d.imm      = imm;
    id_ex_d.rs1      = inst.r.rs1;
    id_ex_d.rs2      = inst.r.rs2;
    id_ex_d.rd       = inst.r.rd;
  end

  always_ff @(posedge clk) begin
    if (reset)
      id_ex.ctrl <= '0;
    else
      id_ex <= id_ex_d;
  end
endmodule

//--- source/fetch_stage.sv
// instruction fetch
`include "rv_macros.svh"

module fetch_stage (
  input  logic               clk,
  input  logic               reset,
  input  logic               stall,
  input  logic               redirect,
  input  logic [`XLEN-1:0]   redirect_pc,
  output logic [`XLEN-1:0]   imem_addr,
  input  logic [`XLEN-1:0]   imem_data,
  output pipe_pkg::if_id_t   if_id
);
  logic [`XLEN-1:0] pc;

  assign imem_addr = pc;  // imem answers in the same cycle

  always_ff @(posedge clk) begin
    if (reset) begin
      pc          <= '0;
      if_id.valid <= 1'b0;
    end else if (redirect) begin  // taken branch/jal beats stall
      pc          <= redirect_pc;
      if_id.valid <= 1'b0;        // drop the wrong-path word
    end else if (!stall) begin
      pc    <= pc + `XLEN'(`PC_STEP);
      if_id <= '{valid: 1'b1, pc: pc, inst: imem_data};
    end
    // stalled: pc and if_id hold
  end
endmodule

//--- source/register_file.sv
// integer register file
`include "rv_macros.svh"

module register_file (
  input  logic                   clk,
  input  logic                   reset,
  input  logic [`REG_ADDR_W-1:0] rs1_addr,
  input  logic [`REG_ADDR_W-1:0] rs2_addr,
  input  logic [`REG_ADDR_W-1:0] rd,
  input  logic [`XLEN-1:0]       rd_din,
  input  logic                   write_enable,
  output logic [`XLEN-1:0]       rs1_dout,
  output logic [`XLEN-1:0]       rs2_dout,
  output logic [`XLEN-1:0]       print_reg [`REG_COUNT]
);
  logic [`XLEN-1:0] regs [`REG_COUNT];
  logic             wr;

  assign wr = write_enable && rd != '0;  // x0 stays zero

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `REG_COUNT; i++)
        regs[i] <= '0;
    end else if (wr) begin
      regs[rd] <= rd_din;
    end
  end

  // same-cycle write shows through to the reads
  assign rs1_dout  = (wr && rd == rs1_addr) ? rd_din : regs[rs1_addr];
  assign rs2_dout  = (wr && rd == rs2_addr) ? rd_din : regs[rs2_addr];
  assign print_reg = regs;
endmodule

//--- source/bypass_if.sv
// result bypass bundle
`include "rv_macros.svh"

interface bypass_if;
  logic [`REG_ADDR_W-1:0] mem_rd;
  logic                   mem_reg_write;
  logic                   mem_mem_read;   // mem_value is an address, not data
  logic [`XLEN-1:0]       mem_value;
  logic [`REG_ADDR_W-1:0] wb_rd;
  logic                   wb_reg_write;   // already gated by halt
  logic [`XLEN-1:0]       wb_value;

  modport source (output mem_rd, mem_reg_write, mem_mem_read, mem_value,
                  output wb_rd, wb_reg_write, wb_value);
  modport fwd (input mem_rd, mem_reg_write, mem_value, wb_rd, wb_reg_write, wb_value);
  modport dec (input mem_rd, mem_reg_write, mem_mem_read, mem_value,
               input wb_rd, wb_reg_write, wb_value);
endinterface

//--- source/pipe_pkg.sv
// pipeline register records
`include "rv_macros.svh"

package pipe_pkg;

  typedef struct packed {
    logic             valid;
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] inst;
  } if_id_t;

  typedef struct packed {
    rv_isa_pkg::ctrl_t      ctrl;      // all zero means bubble
    logic [`XLEN-1:0]       pc;
    logic [`XLEN-1:0]       rs1_data;
    logic [`XLEN-1:0]       rs2_data;
    logic [`XLEN-1:0]       imm;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`REG_ADDR_W-1:0] rd;
  } id_ex_t;

  typedef struct packed {
    rv_isa_pkg::ctrl_t      ctrl;
    logic [`XLEN-1:0]       alu_out;     // also the load/store address
    logic [`XLEN-1:0]       store_data;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       link;        // pc + 4 for jal
  } ex_mem_t;

endpackage

//--- source/rv_isa_pkg.sv
// rv32i subset encodings
`include "rv_macros.svh"

package rv_isa_pkg;

  typedef enum logic [6:0] {
    OP_R      = 7'b0110011,  // add sub and or xor slt
    OP_IMM    = 7'b0010011,  // addi andi ori xori
    OP_LOAD   = 7'b0000011,  // lw
    OP_STORE  = 7'b0100011,  // sw
    OP_BRANCH = 7'b1100011,  // beq bne
    OP_JAL    = 7'b1101111,
    OP_SYSTEM = 7'b1110011   // ecall only
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT
  } alu_op_e;

  typedef struct packed {
    logic [6:0]             funct7;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [2:0]             funct3;
    logic [`REG_ADDR_W-1:0] rd;
    opcode_e                opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0]            imm;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [2:0]             funct3;
    logic [`REG_ADDR_W-1:0] rd;
    opcode_e                opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0]             imm_hi;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [2:0]             funct3;
    logic [4:0]             imm_lo;
    opcode_e                opcode;
  } s_fmt_t;

  // branch offset bits scattered, bit 0 implied
  typedef struct packed {
    logic                   imm12;
    logic [5:0]             imm10_5;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [2:0]             funct3;
    logic [3:0]             imm4_1;
    logic                   imm11;
    opcode_e                opcode;
  } b_fmt_t;

  typedef struct packed {
    logic                   imm20;
    logic [9:0]             imm10_1;
    logic                   imm11;
    logic [7:0]             imm19_12;
    logic [`REG_ADDR_W-1:0] rd;
    opcode_e                opcode;
  } j_fmt_t;

  // one fetched word, five views
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    j_fmt_t j;
  } inst_u;

  typedef struct packed {
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;
    logic    alu_src;    // imm as operand b
    logic    is_branch;
    logic    branch_ne;  // bne, else beq
    logic    is_jal;
    logic    is_halt;    // ecall with a7 == halt code
    alu_op_e alu_op;
  } ctrl_t;

endpackage

//--- source/rv_macros.svh
// core width and constant macros
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// datapath and address width
`define XLEN 32

// register file geometry
`define REG_COUNT 32
`define REG_ADDR_W 5

// data memory depth in words
`define DMEM_WORDS 64

// a7 holds the ecall service code
`define ECALL_ARG_REG 17
`define HALT_CODE 10

// sequential pc increment
`define PC_STEP 4

`endif
